// File: mpu_defines.svh
`ifndef MPU_DEFINES_SVH
`define MPU_DEFINES_SVH

// ----------------------------------------------------------------------
// Matrix geometry
// ----------------------------------------------------------------------

// Largest row count of one matrix register
`define MPU_M 4

// Largest column count of one matrix register
`define MPU_N 4

// ----------------------------------------------------------------------
// Register file and datapath
// ----------------------------------------------------------------------

`define MPU_REGS 8       // Matrix registers in the file

// Element width, two's complement integer
`define MPU_ELEM_W 32

`endif

// File: mpu_pkg.sv
package mpu_pkg;

    `include "mpu_defines.svh"

    // ----------------------------------------------------------------------
    // Scalar types
    // ----------------------------------------------------------------------

    typedef logic [`MPU_ELEM_W-1:0]         elem_t;     // One matrix element
    typedef logic [$clog2(`MPU_REGS)-1:0]   reg_idx_t;  // Register number
    typedef logic [$clog2(`MPU_M)-1:0]      row_idx_t;  // Row position
    typedef logic [$clog2(`MPU_N)-1:0]      col_idx_t;  // Column position

    // Count from 1 to 4, zero means never written
    typedef logic [$clog2(`MPU_M+1)-1:0]    size_t;

    // ----------------------------------------------------------------------
    // Opcodes and states
    // ----------------------------------------------------------------------

    typedef enum logic [2:0] {
        OP_LOAD,            // Fill dst from elem_in stream
        OP_STORE,           // Stream src_a out
        OP_ADD,
        OP_SUB,
        OP_MUL,             // Low half of product
        OP_TRANS            // dst = transpose of src_a
    } mpu_op_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL,
        ALU_PASS            // Operand a unchanged
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_OP,
        ST_STORE
    } ctrl_state_e;

    // ----------------------------------------------------------------------
    // Bundles
    // ----------------------------------------------------------------------

    // Command word, rows/cols set the walk for every opcode
    typedef struct packed {
        mpu_op_e  op;
        reg_idx_t dst;
        reg_idx_t src_a;
        reg_idx_t src_b;
        size_t    rows;
        size_t    cols;
    } mpu_cmd_t;

    // Register file write, sizes land in the target register
    typedef struct packed {
        logic     en;
        reg_idx_t addr;
        row_idx_t i;
        col_idx_t j;
        elem_t    data;
        size_t    rows;
        size_t    cols;
    } rf_write_t;

    // Register file read request
    typedef struct packed {
        logic     en;
        reg_idx_t addr;
        row_idx_t i;
        col_idx_t j;
    } rf_read_t;

endpackage

// File: mpu_register_file.sv
`timescale 1ns/1ps
`include "mpu_defines.svh"

module mpu_register_file
    import mpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  rf_write_t wr,           // Element write plus sizes
    input  rf_read_t  rd_a,         // Port A, also returns sizes
    input  rf_read_t  rd_b,         // Port B, element only
    output elem_t     rd_a_data,
    output elem_t     rd_b_data,
    output size_t     rd_a_rows,
    output size_t     rd_a_cols
);

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------

    elem_t mat_q  [`MPU_REGS][`MPU_M][`MPU_N];  // Element array
    size_t rows_q [`MPU_REGS];                  // Row count per register
    size_t cols_q [`MPU_REGS];                  // Column count per register

    // Element write
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mat_q[wr.addr][wr.i][wr.j] <= wr.data;
        end
    end

    // Sizes follow every write to the register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `MPU_REGS; r++) begin
                rows_q[r] <= '0;        // Empty until loaded
                cols_q[r] <= '0;
            end
        end else if (wr.en) begin
            rows_q[wr.addr] <= wr.rows;
            cols_q[wr.addr] <= wr.cols;
        end
    end

    // ----------------------------------------------------------------------
    // Read ports with one cycle latency
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rd_a.en) begin
            rd_a_data <= mat_q[rd_a.addr][rd_a.i][rd_a.j];
            rd_a_rows <= rows_q[rd_a.addr];     // For STORE output
            rd_a_cols <= cols_q[rd_a.addr];     // and destination sizing
        end
    end

    // Port B feeds the second ALU operand only
    always_ff @(posedge clk) begin
        if (rd_b.en) begin
            rd_b_data <= mat_q[rd_b.addr][rd_b.i][rd_b.j];
        end
    end

endmodule

// File: mpu_alu.sv
`timescale 1ns/1ps

module mpu_alu
    import mpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    valid,          // Operands present this cycle
    input  alu_op_e op,
    input  elem_t   a,
    input  elem_t   b,
    output elem_t   result,
    output logic    result_valid
);

    logic [2*$bits(elem_t)-1:0] prod;   // Full width product

    assign prod = a * b;

    // Result register, wraps in two's complement
    always_ff @(posedge clk) begin
        if (valid) begin
            case (op)
                ALU_ADD:  result <= a + b;
                ALU_SUB:  result <= a - b;
                ALU_MUL:  result <= prod[$bits(elem_t)-1:0];    // Low bits only
                default:  result <= a;                          // Pass for TRANS
            endcase
        end
    end

    // Valid trails the operands by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= valid;
        end
    end

endmodule

// File: mpu_controller.sv
`timescale 1ns/1ps

module mpu_controller
    import mpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // Command and load stream
    input  logic      cmd_valid,
    input  mpu_cmd_t  cmd,
    input  logic      elem_in_valid,
    input  elem_t     elem_in,
    // Register file return path
    input  elem_t     rd_a_data,
    input  size_t     rd_a_rows,
    input  size_t     rd_a_cols,
    // ALU return path
    input  elem_t     alu_result,
    input  logic      alu_result_valid,
    // Register file requests
    output rf_write_t rf_wr,
    output rf_read_t  rd_a,
    output rf_read_t  rd_b,
    // ALU control
    output alu_op_e   alu_op,
    output logic      alu_valid,
    // Status and store stream
    output logic      busy,
    output logic      done,
    output logic      elem_out_valid,
    output elem_t     elem_out,
    output size_t     out_rows,
    output size_t     out_cols
);

    // Position tag riding along with each element in flight
    typedef struct packed {
        logic     valid;
        logic     store;    // Goes to elem_out, not the ALU
        logic     last;     // Final element of the walk
        row_idx_t i;        // Destination row
        col_idx_t j;        // Destination column
    } tag_t;

    ctrl_state_e state_q;
    mpu_cmd_t    cmd_q;             // Latched command
    row_idx_t    row_q;             // Walk position
    col_idx_t    col_q;
    logic        issue_q;           // Reads still to issue
    logic        done_q;
    tag_t        s1_q;              // Read data stage
    tag_t        s2_q;              // ALU result stage
    size_t       dst_rows_q;        // Destination sizes from src_a
    size_t       dst_cols_q;

    logic        accept;
    logic        reading;
    logic        load_beat;
    logic        last_row;
    logic        last_col;
    logic        last_pos;
    logic        trans;
    logic        wr_fire;

    // ----------------------------------------------------------------------
    // Sequencing terms
    // ----------------------------------------------------------------------

    assign busy      = (state_q != ST_IDLE);
    assign accept    = cmd_valid && !busy;          // Dropped while busy
    assign trans     = (cmd_q.op == OP_TRANS);
    assign load_beat = (state_q == ST_LOAD) && elem_in_valid;
    assign reading   = issue_q && (state_q == ST_STORE || state_q == ST_OP);

    // Walk bounds come from the command for every opcode
    assign last_row  = (row_q == row_idx_t'(cmd_q.rows - size_t'(1)));
    assign last_col  = (col_q == col_idx_t'(cmd_q.cols - size_t'(1)));
    assign last_pos  = last_row && last_col;

    assign wr_fire   = (state_q == ST_OP) && alu_result_valid && s2_q.valid;

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd;
        end
    end

    // FSM, done is a one cycle pulse as the FSM returns to idle
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            issue_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        issue_q <= (cmd.op != OP_LOAD);
                        case (cmd.op)
                            OP_LOAD:  state_q <= ST_LOAD;
                            OP_STORE: state_q <= ST_STORE;
                            default:  state_q <= ST_OP;
                        endcase
                    end
                end
                ST_LOAD: begin
                    if (load_beat && last_pos) begin
                        state_q <= ST_IDLE;
                        done_q  <= 1'b1;        // Cycle after last element
                    end
                end
                ST_STORE: begin
                    if (last_pos) begin
                        issue_q <= 1'b0;
                        state_q <= ST_IDLE;
                        done_q  <= 1'b1;        // Lines up with last output
                    end
                end
                default: begin                  // ST_OP
                    if (reading && last_pos) begin
                        issue_q <= 1'b0;        // Pipe still draining
                    end
                    if (wr_fire && s2_q.last) begin
                        state_q <= ST_IDLE;
                        done_q  <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Row-major walk, shared by load beats and reads
    always_ff @(posedge clk) begin
        if (rst) begin
            row_q <= '0;
            col_q <= '0;
        end else if (accept) begin
            row_q <= '0;
            col_q <= '0;
        end else if (load_beat || reading) begin
            if (last_col) begin
                col_q <= '0;
                row_q <= row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Tag pipeline, matches read and ALU latency
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_q <= '0;
            s2_q <= '0;
        end else begin
            s1_q.valid <= reading;
            s1_q.store <= (state_q == ST_STORE);
            s1_q.last  <= last_pos;
            s1_q.i     <= trans ? row_idx_t'(col_q) : row_q;    // Swapped for TRANS
            s1_q.j     <= trans ? col_idx_t'(row_q) : col_q;
            s2_q       <= s1_q;
            s2_q.valid <= s1_q.valid && !s1_q.store;            // Only ALU traffic
        end
    end

    // Source A sizes show up with the first element
    always_ff @(posedge clk) begin
        if (rst) begin
            dst_rows_q <= '0;
            dst_cols_q <= '0;
        end else if (alu_valid && s1_q.i == '0 && s1_q.j == '0) begin
            dst_rows_q <= trans ? rd_a_cols : rd_a_rows;
            dst_cols_q <= trans ? rd_a_rows : rd_a_cols;
        end
    end

    // ----------------------------------------------------------------------
    // Requests and outputs
    // ----------------------------------------------------------------------

    // STORE reads src_a, operations read src_a and src_b
    assign rd_a = '{en: reading, addr: cmd_q.src_a, i: row_q, j: col_q};
    assign rd_b = '{en: reading && (state_q == ST_OP), addr: cmd_q.src_b,
                    i: row_q, j: col_q};

    // Load beats write directly, operations write from the ALU
    always_comb begin
        rf_wr      = '0;
        rf_wr.addr = cmd_q.dst;
        if (state_q == ST_LOAD) begin
            rf_wr.en   = elem_in_valid;
            rf_wr.i    = row_q;
            rf_wr.j    = col_q;
            rf_wr.data = elem_in;
            rf_wr.rows = cmd_q.rows;
            rf_wr.cols = cmd_q.cols;
        end else begin
            rf_wr.en   = wr_fire;
            rf_wr.i    = s2_q.i;
            rf_wr.j    = s2_q.j;
            rf_wr.data = alu_result;
            rf_wr.rows = dst_rows_q;
            rf_wr.cols = dst_cols_q;
        end
    end

    always_comb begin
        case (cmd_q.op)
            OP_ADD:  alu_op = ALU_ADD;
            OP_SUB:  alu_op = ALU_SUB;
            OP_MUL:  alu_op = ALU_MUL;
            default: alu_op = ALU_PASS;
        endcase
    end

    assign alu_valid      = s1_q.valid && !s1_q.store;
    assign elem_out_valid = s1_q.valid && s1_q.store;
    assign elem_out       = rd_a_data;      // Straight from port A
    assign out_rows       = rd_a_rows;      // Stored sizes of the register
    assign out_cols       = rd_a_cols;
    assign done           = done_q;

endmodule

// File: mpu_top.sv
`timescale 1ns/1ps

module mpu_top
    import mpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    // Command strobe
    input  logic     cmd_valid,
    input  mpu_cmd_t cmd,
    // LOAD element stream
    input  logic     elem_in_valid,
    input  elem_t    elem_in,
    // Status
    output logic     busy,
    output logic     done,
    // STORE element stream
    output logic     elem_out_valid,
    output elem_t    elem_out,
    output size_t    out_rows,
    output size_t    out_cols
);

    // ----------------------------------------------------------------------
    // Internal buses
    // ----------------------------------------------------------------------

    rf_write_t rf_wr;
    rf_read_t  rd_a;
    rf_read_t  rd_b;
    elem_t     rd_a_data;
    elem_t     rd_b_data;           // Second operand, ALU only
    size_t     rd_a_rows;
    size_t     rd_a_cols;
    alu_op_e   alu_op;
    logic      alu_valid;
    elem_t     alu_result;
    logic      alu_result_valid;

    mpu_controller mpu_controller_i (
        .clk              (clk),
        .rst              (rst),
        .cmd_valid        (cmd_valid),
        .cmd              (cmd),
        .elem_in_valid    (elem_in_valid),
        .elem_in          (elem_in),
        .rd_a_data        (rd_a_data),
        .rd_a_rows        (rd_a_rows),
        .rd_a_cols        (rd_a_cols),
        .alu_result       (alu_result),
        .alu_result_valid (alu_result_valid),
        .rf_wr            (rf_wr),
        .rd_a             (rd_a),
        .rd_b             (rd_b),
        .alu_op           (alu_op),
        .alu_valid        (alu_valid),
        .busy             (busy),
        .done             (done),
        .elem_out_valid   (elem_out_valid),
        .elem_out         (elem_out),
        .out_rows         (out_rows),
        .out_cols         (out_cols)
    );

    mpu_register_file mpu_register_file_i (
        .clk       (clk),
        .rst       (rst),
        .wr        (rf_wr),
        .rd_a      (rd_a),
        .rd_b      (rd_b),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data),
        .rd_a_rows (rd_a_rows),
        .rd_a_cols (rd_a_cols)
    );

    // Operands straight off both read ports
    mpu_alu mpu_alu_i (
        .clk          (clk),
        .rst          (rst),
        .valid        (alu_valid),
        .op           (alu_op),
        .a            (rd_a_data),
        .b            (rd_b_data),
        .result       (alu_result),
        .result_valid (alu_result_valid)
    );

endmodule

// File: tb_mpu_top.sv
`timescale 1ns/1ps

module tb_mpu_top
    import mpu_pkg::*;
();

    localparam string GOLDEN_FILE  = "mpu_golden.txt";
    localparam int    RST_CYCLES   = 5;
    localparam int    DONE_TIMEOUT = 64;    // Cycles allowed for one command

    // ----------------------------------------------------------------------
    // DUT, clock and bookkeeping
    // ----------------------------------------------------------------------

    logic     clk = 1'b0;
    logic     rst;
    logic     cmd_valid;
    mpu_cmd_t cmd;
    logic     elem_in_valid;
    elem_t    elem_in;
    logic     busy;
    logic     done;
    logic     elem_out_valid;
    elem_t    elem_out;
    size_t    out_rows;
    size_t    out_cols;

    string       lines [$];             // Golden records without comments
    int          pos;                   // Next record to consume
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    logic        timeout_hit;
    logic [31:0] lcg_state;
    logic        inject_pending;        // Extra strobe rides on the next command
    mpu_cmd_t    inject_cmd;

    always #5 clk = ~clk;               // 10 ns period

    mpu_top mpu_top_i (
        .clk            (clk),
        .rst            (rst),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .elem_in_valid  (elem_in_valid),
        .elem_in        (elem_in),
        .busy           (busy),
        .done           (done),
        .elem_out_valid (elem_out_valid),
        .elem_out       (elem_out),
        .out_rows       (out_rows),
        .out_cols       (out_cols)
    );

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic flag_error(string msg);
        $display("[FAIL] t=%0t %s", $time, msg);
        test_errors++;
    endtask

    // Record layout is kind op dst src_a src_b rows cols
    function automatic mpu_cmd_t parse_cmd(string line);
        int       kind;
        int       op;
        int       dst;
        int       sa;
        int       sb;
        int       nr;
        int       nc;
        mpu_cmd_t c;
        if ($sscanf(line, "%c %d %d %d %d %d %d", kind, op, dst, sa, sb, nr, nc) != 7) begin
            $display("Golden file has a broken command record: %s", line);
            test_errors++;
        end
        c.op    = mpu_op_e'(op[2:0]);
        c.dst   = reg_idx_t'(dst);
        c.src_a = reg_idx_t'(sa);
        c.src_b = reg_idx_t'(sb);
        c.rows  = size_t'(nr);
        c.cols  = size_t'(nc);
        return c;
    endfunction

    task automatic read_golden();
        int    fd;
        string line;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the golden file %s", GOLDEN_FILE);
            tests_failed++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);      // Comment lines dropped
                end
            end
            $fclose(fd);
        end
    endtask

    // Strobe one command and any pending second one while busy
    task automatic send_cmd(mpu_cmd_t c);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(posedge clk);
        if (inject_pending) begin
            cmd <= inject_cmd;                  // Strobe held into the busy cycle
            @(negedge clk);
            assert (busy) else flag_error("busy low in the cycle after acceptance");
            @(posedge clk);
            inject_pending = 1'b0;
        end
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_done(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!done && cycles < DONE_TIMEOUT);
        if (!done) begin
            $display("Timeout: done did not pulse within %0d cycles at t=%0t",
                     DONE_TIMEOUT, $time);
            timeout_hit = 1'b1;
        end
    endtask

    // ----------------------------------------------------------------------
    // Command runners
    // ----------------------------------------------------------------------

    task automatic load_matrix(mpu_cmd_t c);
        int          n;
        int          cycles;
        logic [31:0] r;
        elem_t       d;
        n = int'(c.rows) * int'(c.cols);
        send_cmd(c);
        for (int k = 0; k < n; k++) begin
            d = '0;
            if ($sscanf(lines[pos], "D %h", d) != 1) begin
                $display("Golden record %0d should be a load element", pos);
                test_errors++;
            end
            pos++;
            r = lcg_next();
            repeat (r[17:16]) begin             // 0 to 3 idle cycles
                @(posedge clk);
                elem_in_valid <= 1'b0;
            end
            @(posedge clk);
            elem_in_valid <= 1'b1;
            elem_in       <= d;
        end
        @(posedge clk);
        elem_in_valid <= 1'b0;
        wait_done(cycles);
        if (!timeout_hit) begin
            assert (cycles == 1)
                else flag_error($sformatf("LOAD done came %0d cycles after last element",
                                          cycles));
        end
    endtask

    task automatic execute_op(mpu_cmd_t c);
        int cycles;
        send_cmd(c);
        wait_done(cycles);
    endtask

    task automatic check_store(mpu_cmd_t c);
        elem_t exp_data [$];
        int    exp_rows [$];
        int    exp_cols [$];
        elem_t d;
        int    er;
        int    ec;
        int    n;
        int    got;
        int    cycles;
        logic  seen_done;
        n = int'(c.rows) * int'(c.cols);
        for (int k = 0; k < n; k++) begin
            if ($sscanf(lines[pos], "E %h %d %d", d, er, ec) != 3) begin
                $display("Golden record %0d should be an expected output", pos);
                test_errors++;
            end
            exp_data.push_back(d);
            exp_rows.push_back(er);
            exp_cols.push_back(ec);
            pos++;
        end
        send_cmd(c);
        got       = 0;
        cycles    = 0;                          // Strobe cycle is cycle 0
        seen_done = 1'b0;
        while (!seen_done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (elem_out_valid) begin
                assert (cycles == got + 2)
                    else flag_error($sformatf("output %0d in cycle %0d, expected cycle %0d",
                                              got, cycles, got + 2));
                assert (got < n)
                    else flag_error($sformatf("extra output %h beyond %0d elements",
                                              elem_out, n));
                if (got < n) begin
                    assert (elem_out == exp_data[got])
                        else flag_error($sformatf("elem %0d got %h expected %h",
                                                  got, elem_out, exp_data[got]));
                    assert (out_rows == exp_rows[got] && out_cols == exp_cols[got])
                        else flag_error($sformatf("elem %0d sizes %0dx%0d expected %0dx%0d",
                                                  got, out_rows, out_cols,
                                                  exp_rows[got], exp_cols[got]));
                end
                got++;
            end
            seen_done = done;
        end
        if (!seen_done) begin
            $display("Timeout: STORE did not finish within %0d cycles", DONE_TIMEOUT);
            timeout_hit = 1'b1;
        end else begin
            assert (elem_out_valid && got == n)     // Done rides on the last output
                else flag_error($sformatf("done after %0d of %0d outputs", got, n));
        end
    endtask

    task automatic finish_test(string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin
        string    line;
        mpu_cmd_t c;
        rst            = 1'b1;
        cmd_valid      = 1'b0;
        cmd            = '0;
        elem_in_valid  = 1'b0;
        elem_in        = '0;
        lcg_state      = 32'h9a34_e6ee;
        pos            = 0;
        test_errors    = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        timeout_hit    = 1'b0;
        inject_pending = 1'b0;
        inject_cmd     = '0;
        read_golden();

        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!busy && !done && !elem_out_valid)
            else flag_error("status outputs not idle after reset");
        finish_test("reset");

        while (pos < lines.size() && !timeout_hit) begin
            line = lines[pos];
            pos++;
            case (line.getc(0))
                "I": begin
                    inject_cmd     = parse_cmd(line);
                    inject_pending = 1'b1;
                end
                "C": begin
                    c = parse_cmd(line);
                    case (c.op)
                        OP_LOAD:  load_matrix(c);
                        OP_STORE: check_store(c);
                        default:  execute_op(c);
                    endcase
                end
                "T":     finish_test(line.substr(2, line.len() - 2));
                default: begin
                    $display("Golden record %0d has an unknown kind", pos - 1);
                    test_errors++;
                end
            endcase
        end

        if (timeout_hit) begin
            tests_failed++;
            $display("test aborted by timeout");
        end
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && test_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: mpu_golden.txt
# C op dst src_a src_b rows cols : command, op 0 LOAD 1 STORE 2 ADD 3 SUB 4 MUL 5 TRANS
# I op dst src_a src_b rows cols : extra command strobed while the next C is busy
# D elem : LOAD element in hex, row-major
# E elem rows cols : expected STORE element in hex with the register sizes
# T name : end of test
C 0 0 0 0 4 4
D 01020304
D 05060708
D 090a0b0c
D 0d0e0f10
D 11121314
D 15161718
D 191a1b1c
D 1d1e1f20
D 21222324
D 25262728
D 292a2b2c
D 2d2e2f30
D 31323334
D 35363738
D 393a3b3c
D 3d3e3f40
C 1 0 0 0 4 4
E 01020304 4 4
E 05060708 4 4
E 090a0b0c 4 4
E 0d0e0f10 4 4
E 11121314 4 4
E 15161718 4 4
E 191a1b1c 4 4
E 1d1e1f20 4 4
E 21222324 4 4
E 25262728 4 4
E 292a2b2c 4 4
E 2d2e2f30 4 4
E 31323334 4 4
E 35363738 4 4
E 393a3b3c 4 4
E 3d3e3f40 4 4
T load_store_4x4
C 0 1 0 0 2 3
D deadbeef
D 00000001
D 80000000
D ffffffff
D 12345678
D 0000abcd
C 1 0 1 0 2 3
E deadbeef 2 3
E 00000001 2 3
E 80000000 2 3
E ffffffff 2 3
E 12345678 2 3
E 0000abcd 2 3
T load_store_2x3
C 0 2 0 0 1 3
D 7fffffff
D 00012345
D fffffffe
C 0 3 0 0 1 3
D 00000001
D 00010000
D 00000003
C 2 4 2 3 1 3
C 1 0 4 0 1 3
E 80000000 1 3
E 00022345 1 3
E 00000001 1 3
C 3 5 2 3 1 3
C 1 0 5 0 1 3
E 7ffffffe 1 3
E 00002345 1 3
E fffffffb 1 3
C 4 4 2 3 1 3
C 1 0 4 0 1 3
E 7fffffff 1 3
E 23450000 1 3
E fffffffa 1 3
T add_sub_mul
C 5 6 1 0 2 3
C 1 0 6 0 3 2
E deadbeef 3 2
E ffffffff 3 2
E 00000001 3 2
E 12345678 3 2
E 80000000 3 2
E 0000abcd 3 2
T trans_2x3
I 2 5 0 0 4 4
C 3 5 3 2 1 3
C 1 0 5 0 1 3
E 80000002 1 3
E ffffdcbb 1 3
E 00000005 1 3
T busy_ignore

// File: mpu_top.f
+incdir+.
mpu_pkg.sv
mpu_register_file.sv
mpu_alu.sv
mpu_controller.sv
mpu_top.sv
tb_mpu_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mpu_top -f mpu_top.f -o tb_mpu_top

out=$(./obj_dir/tb_mpu_top)
echo "$out"

echo "$out" | grep -q "RESULT: PASS"
